// File: source/pcs_pkg.sv
////////////////////
// shared types, marker codes and register map for the rx deskew
// modules take it in with a wildcard import in their header
////////////////////
`default_nettype none

package pcs_pkg;

	// one 64b/66b block
	localparam int BLOCK_W = 66;

	// wishbone data and address widths
	localparam int WB_DW = 32;
	localparam int WB_AW = 2;

	// skew byte per lane, saturating overflow counter
	localparam int SKEW_W = 8;
	localparam int OVF_W = 16;

	// markers travel as control blocks
	localparam logic [1:0] AM_SYNC = 2'b10;

	// same 64 bits, seen as data or as marker bytes
	typedef union packed {
		logic [63:0] raw;
		struct packed {
			logic [7:0] m0;
			logic [7:0] m1;
			logic [7:0] m2;
			logic [7:0] bip3;
			logic [7:0] m4;
			logic [7:0] m5;
			logic [7:0] m6;
			logic [7:0] bip7;
		} am;
	} pcs_payload_u;

	typedef struct packed {
		logic [1:0] sh;
		pcs_payload_u pl;
	} pcs_block_t;

	// m0 m1 m2 per lane, 40G lane marker values
	localparam logic [23:0] am_code_table [4] = '{
		24'h907647, 24'hF0C4E6, 24'hC5659B, 24'hA2793D
	};

	// word addresses of the status and control registers
	typedef enum logic [WB_AW-1:0] {
		REG_STATUS = 2'd0,
		REG_SKEW = 2'd1,
		REG_OVF = 2'd2,
		REG_CTRL = 2'd3
	} csr_addr_e;

endpackage

`default_nettype wire

// File: source/lane_if.sv
////////////////////
// lane_if carries decoded blocks from a marker detector to its lane buffer
// buf_if links one lane buffer to the common deskew control
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface lane_if import pcs_pkg::*; ();
	// block qualifier
	logic valid;
	// this block is the lane marker
	logic am;
	// lite lock held
	logic am_lock;
	pcs_block_t data;

	modport det (output valid, am, am_lock, data);
	modport lane (input valid, am, am_lock, data);
endinterface

interface buf_if import pcs_pkg::*; #(
	parameter int FILL_W = 4
) ();
	logic [FILL_W-1:0] fill;
	// oldest stored block, read out when rd_en pops it
	pcs_block_t head;
	logic head_am;
	logic ovf;
	// drop input until the marker is stored
	logic arm;
	// pop on every lane together
	logic rd_en;
	// empty the buffer
	logic flush;

	modport lane (output fill, head, head_am, ovf, input arm, rd_en, flush);
	modport ctrl (input fill, head_am, ovf, output arm, rd_en, flush);
endinterface

`default_nettype wire

// File: source/am_detect.sv
////////////////////
// per-lane alignment marker match and lite lock
// outputs are registered, one cycle after the input block
////////////////////
`timescale 1ns/1ps
`default_nettype none

module am_detect import pcs_pkg::*; #(
	parameter int LANE_ID = 0,
	parameter int AM_PERIOD = 32
)(
	input wire logic clk,
	input wire logic reset_i,
	input wire logic lock_i,
	input wire logic valid_i,
	input wire pcs_block_t data_i,
	lane_if.det det
);
	localparam int CNT_W = (AM_PERIOD > 2) ? $clog2(AM_PERIOD) : 1;

	logic [23:0] code;
	logic match;
	logic at_period;
	// blocks seen since the last marker
	logic [CNT_W-1:0] cnt_q;
	// a first marker has been found
	logic seen_q;
	logic lock_q;
	logic valid_q;
	logic am_q;
	pcs_block_t data_q;

	assign code = am_code_table[LANE_ID];

	// control header, lane code, then the inverted copy
	assign match = (data_i.sh == AM_SYNC)
		&& ({data_i.pl.am.m0, data_i.pl.am.m1, data_i.pl.am.m2} == code)
		&& ({data_i.pl.am.m4, data_i.pl.am.m5, data_i.pl.am.m6} == ~code);

	// next block lands exactly one period after the last marker
	assign at_period = (cnt_q == CNT_W'(AM_PERIOD - 1));

	// spacing tracker, block lock loss restarts it
	always_ff @(posedge clk) begin
		if (reset_i || !lock_i) begin
			cnt_q <= '0;
			seen_q <= 1'b0;
			lock_q <= 1'b0;
		end else if (valid_i) begin
			if (match) begin
				// right spacing locks, wrong spacing restarts here
				lock_q <= seen_q && at_period;
				seen_q <= 1'b1;
				cnt_q <= '0;
			end else if (seen_q && at_period) begin
				// marker missing where expected
				lock_q <= 1'b0;
				seen_q <= 1'b0;
				cnt_q <= '0;
			end else if (seen_q) begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_q <= 1'b0;
			am_q <= 1'b0;
		end else begin
			valid_q <= valid_i && lock_i;
			am_q <= valid_i && lock_i && match;
		end
	end

	// block payload
	always_ff @(posedge clk) begin
		if (valid_i) begin
			data_q <= data_i;
		end
	end

	assign det.valid = valid_q;
	assign det.am = am_q;
	assign det.am_lock = lock_q;
	assign det.data = data_q;

endmodule

`default_nettype wire

// File: source/deskew_lane.sv
////////////////////
// per-lane skew buffer, a circular FIFO with fill count
// while armed, blocks ahead of the marker are dropped so the marker becomes the head
////////////////////
`timescale 1ns/1ps
`default_nettype none

module deskew_lane import pcs_pkg::*; #(
	parameter int MAX_SKEW_BLOCK_N = 8
)(
	input wire logic clk,
	input wire logic reset_i,
	lane_if.lane ln,
	buf_if.lane bf
);
	localparam int DEPTH = MAX_SKEW_BLOCK_N;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int FILL_W = $clog2(DEPTH + 1);

	pcs_block_t mem [DEPTH];
	// marker flag stored next to each block
	logic am_mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [FILL_W-1:0] fill_q;
	// marker already stored in this arm phase
	logic synced_q;
	logic ovf_q;

	logic is_mark;
	logic keep;
	logic full;
	logic empty;
	logic wr;
	logic rd;

	// wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// only a locked marker counts as the sync point
	assign is_mark = ln.am && ln.am_lock;

	// block passes the arm gate
	assign keep = ln.valid && !bf.flush && (synced_q || !bf.arm || is_mark);

	assign full = (fill_q == FILL_W'(DEPTH));
	assign empty = (fill_q == '0);
	assign rd = bf.rd_en && !empty;

	// a pop on the same cycle makes room
	assign wr = keep && (!full || rd);

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_ptr_q] <= ln.data;
			am_mem[wr_ptr_q] <= is_mark;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i || bf.flush) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			fill_q <= '0;
			synced_q <= 1'b0;
			ovf_q <= 1'b0;
		end else begin
			if (wr) begin
				wr_ptr_q <= ptr_inc(wr_ptr_q);
			end
			if (rd) begin
				rd_ptr_q <= ptr_inc(rd_ptr_q);
			end
			fill_q <= fill_q + FILL_W'(wr) - FILL_W'(rd);
			if (bf.arm && wr && is_mark) begin
				synced_q <= 1'b1;
			end
			// write into a full buffer with no pop, block is lost
			ovf_q <= keep && full && !rd;
		end
	end

	assign bf.fill = fill_q;
	assign bf.head = mem[rd_ptr_q];
	assign bf.head_am = !empty && am_mem[rd_ptr_q];
	assign bf.ovf = ovf_q;

endmodule

`default_nettype wire

// File: source/deskew_ctrl.sv
////////////////////
// deskew control, waits for all locks, arms the lanes, then pops them together
// skew and overflow count are reported to the register slave
////////////////////
`timescale 1ns/1ps
`default_nettype none

module deskew_ctrl import pcs_pkg::*; #(
	parameter int LANE_N = 4,
	parameter int MAX_SKEW_BLOCK_N = 8
)(
	input wire logic clk,
	input wire logic reset_i,
	buf_if.ctrl bf [LANE_N],
	input wire logic [LANE_N-1:0] lock_i,
	input wire logic [LANE_N-1:0] am_lock_i,
	input wire logic realign_i,
	output logic aligned_o,
	output logic data_v_o,
	output logic am_v_o,
	output logic [LANE_N*SKEW_W-1:0] skew_o,
	output logic [OVF_W-1:0] ovf_cnt_o
);
	localparam int FILL_W = $clog2(MAX_SKEW_BLOCK_N + 1);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_ARM = 2'd1;
	localparam logic [1:0] ST_RUN = 2'd2;

	logic [1:0] state_q;
	logic [1:0] state_d;
	logic [LANE_N-1:0][SKEW_W-1:0] skew_q;
	logic [OVF_W-1:0] ovf_cnt_q;

	wire [LANE_N-1:0][FILL_W-1:0] fill;
	wire [LANE_N-1:0] head_am;
	wire [LANE_N-1:0] ovf;
	wire [LANE_N-1:0] non_empty;
	// lane that holds no extra blocks
	wire [LANE_N-1:0] slow_lane;

	logic all_lock;
	logic fault;
	logic rd_en;
	logic go_run;

	for (genvar l = 0; l < LANE_N; l++) begin : g_lane
		assign fill[l] = bf[l].fill;
		assign head_am[l] = bf[l].head_am;
		assign ovf[l] = bf[l].ovf;
		assign non_empty[l] = (bf[l].fill != '0);
		assign slow_lane[l] = (skew_q[l] == '0);
		assign bf[l].arm = (state_q == ST_ARM);
		assign bf[l].rd_en = rd_en;
		assign bf[l].flush = (state_q == ST_IDLE);
	end

	assign all_lock = &lock_i && &am_lock_i;
	assign fault = !all_lock || |ovf || realign_i;
	// every head is a marker, the last lane just stored its own
	assign go_run = (state_q == ST_ARM) && !fault && &head_am;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: if (all_lock && !realign_i) state_d = ST_ARM;
			ST_ARM: begin
				if (fault) state_d = ST_IDLE;
				else if (&head_am) state_d = ST_RUN;
			end
			ST_RUN: if (fault) state_d = ST_IDLE;
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= ST_IDLE;
			skew_q <= '0;
			ovf_cnt_q <= '0;
		end else begin
			state_q <= state_d;
			// slowest lane holds one block here, its skew is zero
			if (go_run) begin
				for (int l = 0; l < LANE_N; l++) begin
					skew_q[l] <= SKEW_W'(fill[l] - 1'b1);
				end
			end
			if (|ovf && ovf_cnt_q != '1) begin
				ovf_cnt_q <= ovf_cnt_q + 1'b1;
			end
		end
	end

	// joint pop once every lane has a block
	assign rd_en = (state_q == ST_RUN) && &non_empty;

	assign aligned_o = (state_q == ST_RUN);
	assign data_v_o = rd_en;
	assign am_v_o = rd_en && |(head_am & slow_lane);
	assign skew_o = skew_q;
	assign ovf_cnt_o = ovf_cnt_q;

endmodule

`default_nettype wire

// File: source/deskew_csr.sv
////////////////////
// wishbone classic slave with status, skew, overflow and realign registers
// ack lasts one cycle, read data comes with it
////////////////////
`timescale 1ns/1ps
`default_nettype none

module deskew_csr import pcs_pkg::*; #(
	parameter int LANE_N = 4
)(
	input wire logic clk,
	input wire logic reset_i,
	input wire logic wb_cyc_i,
	input wire logic wb_stb_i,
	input wire logic wb_we_i,
	input wire logic [WB_AW-1:0] wb_adr_i,
	input wire logic [WB_DW-1:0] wb_dat_i,
	output logic [WB_DW-1:0] wb_dat_o,
	output logic wb_ack_o,
	input wire logic [LANE_N-1:0] lock_i,
	input wire logic aligned_i,
	input wire logic [LANE_N*SKEW_W-1:0] skew_i,
	input wire logic [OVF_W-1:0] ovf_cnt_i,
	output logic realign_o
);
	// access pending, not yet acked
	logic req;
	csr_addr_e addr;
	logic [WB_DW-1:0] rd_data;

	assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;
	assign addr = csr_addr_e'(wb_adr_i);

	// read mux
	always_comb begin
		rd_data = '0;
		case (addr)
			// lock mask in the low bits, aligned at bit 8
			REG_STATUS: begin
				rd_data[LANE_N-1:0] = lock_i;
				rd_data[8] = aligned_i;
			end
			// byte l is lane l
			REG_SKEW: rd_data[LANE_N*SKEW_W-1:0] = skew_i;
			REG_OVF: rd_data[OVF_W-1:0] = ovf_cnt_i;
			default: rd_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb_ack_o <= 1'b0;
			realign_o <= 1'b0;
		end else begin
			wb_ack_o <= req;
			// ctrl bit 0 is self clearing
			realign_o <= req && wb_we_i && (addr == REG_CTRL) && wb_dat_i[0];
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			wb_dat_o <= rd_data;
		end
	end

endmodule

`default_nettype wire

// File: source/pcs_rx_deskew_top.sv
////////////////////
// multi-lane 64b/66b rx deskew, marker lock per lane and joint readout
// set LANE_N, AM_PERIOD and MAX_SKEW_BLOCK_N here
////////////////////
`timescale 1ns/1ps
`default_nettype none

module pcs_rx_deskew_top import pcs_pkg::*; #(
	parameter int LANE_N = 4,
	parameter int AM_PERIOD = 32,
	parameter int MAX_SKEW_BLOCK_N = 8
)(
	input wire logic clk,
	input wire logic reset_i,
	input wire logic [LANE_N-1:0] lock_i,
	input wire logic [LANE_N-1:0] valid_i,
	input wire logic [LANE_N*BLOCK_W-1:0] data_i,
	output wire logic [LANE_N*BLOCK_W-1:0] data_o,
	output logic data_v_o,
	output logic am_v_o,
	output logic aligned_o,
	input wire logic wb_cyc_i,
	input wire logic wb_stb_i,
	input wire logic wb_we_i,
	input wire logic [WB_AW-1:0] wb_adr_i,
	input wire logic [WB_DW-1:0] wb_dat_i,
	output logic [WB_DW-1:0] wb_dat_o,
	output logic wb_ack_o
);
	localparam int FILL_W = $clog2(MAX_SKEW_BLOCK_N + 1);

	wire [LANE_N-1:0] am_lock;
	logic [LANE_N*SKEW_W-1:0] skew;
	logic [OVF_W-1:0] ovf_cnt;
	logic realign;

	lane_if ln [LANE_N] ();
	buf_if #(.FILL_W(FILL_W)) bf [LANE_N] ();

	for (genvar l = 0; l < LANE_N; l++) begin : g_lane
		am_detect #(
			.LANE_ID(l),
			.AM_PERIOD(AM_PERIOD)
		) u_am_detect (
			.clk(clk),
			.reset_i(reset_i),
			.lock_i(lock_i[l]),
			.valid_i(valid_i[l]),
			.data_i(data_i[l*BLOCK_W +: BLOCK_W]),
			.det(ln[l])
		);

		deskew_lane #(
			.MAX_SKEW_BLOCK_N(MAX_SKEW_BLOCK_N)
		) u_deskew_lane (
			.clk(clk),
			.reset_i(reset_i),
			.ln(ln[l]),
			.bf(bf[l])
		);

		assign am_lock[l] = ln[l].am_lock;
		// heads leave together, qualified by data_v_o
		assign data_o[l*BLOCK_W +: BLOCK_W] = bf[l].head;
	end

	deskew_ctrl #(
		.LANE_N(LANE_N),
		.MAX_SKEW_BLOCK_N(MAX_SKEW_BLOCK_N)
	) u_deskew_ctrl (
		.clk(clk),
		.reset_i(reset_i),
		.bf(bf),
		.lock_i(lock_i),
		.am_lock_i(am_lock),
		.realign_i(realign),
		.aligned_o(aligned_o),
		.data_v_o(data_v_o),
		.am_v_o(am_v_o),
		.skew_o(skew),
		.ovf_cnt_o(ovf_cnt)
	);

	deskew_csr #(
		.LANE_N(LANE_N)
	) u_deskew_csr (
		.clk(clk),
		.reset_i(reset_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.lock_i(lock_i),
		.aligned_i(aligned_o),
		.skew_i(skew),
		.ovf_cnt_i(ovf_cnt),
		.realign_o(realign)
	);

endmodule

`default_nettype wire

// File: tb/tb_pcs_rx_deskew.sv
////////////////////
// testbench for the rx deskew, skewed lanes from one block counter
// wishbone tasks read the status, assertions check the aligned output
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_pcs_rx_deskew import pcs_pkg::*; ();
	localparam int LANE_N = 4;
	localparam int AM_PERIOD = 16;
	localparam int MAX_SKEW_BLOCK_N = 8;
	localparam int ALIGN_TIMEOUT = 8 * AM_PERIOD;
	localparam int WB_TIMEOUT = 16;

	logic clk = 1'b0;
	logic reset_i;
	logic [LANE_N-1:0] lock_i;
	logic [LANE_N-1:0] valid_i;
	logic [LANE_N*BLOCK_W-1:0] data_i;
	logic [LANE_N*BLOCK_W-1:0] data_o;
	logic data_v_o;
	logic am_v_o;
	logic aligned_o;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_we_i;
	logic [WB_AW-1:0] wb_adr_i;
	logic [WB_DW-1:0] wb_dat_i;
	logic [WB_DW-1:0] wb_dat_o;
	logic wb_ack_o;

	// source block index and its noise byte, kept for the delayed lanes
	int n = 0;
	logic [31:0] nz = 32'd8;
	logic [7:0] noise_mem [64];
	int skew [LANE_N] = '{0, 3, 5, 1};
	logic [LANE_N-1:0] lock_v = '1;
	logic hold_unaligned = 1'b0;

	int err_cnt = 0;
	int err_base = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int ack_cnt = 0;
	int access_cnt = 0;
	int am_v_cnt = 0;
	string cur_test = "reset";

	pcs_block_t out_blk [LANE_N];
	logic [LANE_N-1:0] mark_mask;
	logic idx_ok;
	logic [55:0] bad_idx;

	pcs_rx_deskew_top #(
		.LANE_N(LANE_N),
		.AM_PERIOD(AM_PERIOD),
		.MAX_SKEW_BLOCK_N(MAX_SKEW_BLOCK_N)
	) u_pcs_rx_deskew_top (
		.clk(clk), .reset_i(reset_i), .lock_i(lock_i), .valid_i(valid_i), .data_i(data_i),
		.data_o(data_o), .data_v_o(data_v_o), .am_v_o(am_v_o), .aligned_o(aligned_o),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o)
	);

	initial begin
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// marker every AM_PERIOD blocks, else index over a noise byte
	function automatic pcs_block_t make_block(input int idx, input int lane);
		pcs_block_t b;
		logic [23:0] code;
		code = am_code_table[lane];
		if (idx % AM_PERIOD == 0) begin
			b.sh = AM_SYNC;
			{b.pl.am.m0, b.pl.am.m1, b.pl.am.m2} = code;
			b.pl.am.bip3 = 8'h00;
			{b.pl.am.m4, b.pl.am.m5, b.pl.am.m6} = ~code;
			b.pl.am.bip7 = 8'hff;
		end else begin
			b.sh = 2'b01;
			b.pl.raw = {56'(idx), noise_mem[idx % 64]};
		end
		return b;
	endfunction

	// lane l lags the source by skew[l] blocks
	always @(negedge clk) begin : drive_lanes
		int m;
		noise_mem[n % 64] = nz[7:0];
		nz = xorshift(nz);
		for (int l = 0; l < LANE_N; l++) begin
			m = n - skew[l];
			valid_i[l] = (m >= 0);
			data_i[l*BLOCK_W +: BLOCK_W] = (m >= 0) ? make_block(m, l) : '0;
		end
		lock_i = lock_v;
		n = n + 1;
	end

	always @(negedge clk) begin
		if (wb_ack_o) ack_cnt++;
		if (am_v_o) am_v_cnt++;
	end

	// output decode per lane
	for (genvar g = 0; g < LANE_N; g++) begin : g_out
		assign out_blk[g] = data_o[g*BLOCK_W +: BLOCK_W];
		assign mark_mask[g] = (out_blk[g].sh == AM_SYNC);
	end

	always_comb begin
		idx_ok = 1'b1;
		bad_idx = out_blk[0].pl.raw[63:8];
		for (int l = 1; l < LANE_N; l++) begin
			if (out_blk[l].pl.raw[63:8] != out_blk[0].pl.raw[63:8]) begin
				idx_ok = 1'b0;
				bad_idx = out_blk[l].pl.raw[63:8];
			end
		end
	end

	a_reset: assert property (@(posedge clk)
		reset_i |=> !(data_v_o || am_v_o || aligned_o || wb_ack_o))
		else begin
			err_cnt++;
			$display("mismatch %s reset outputs expected 0000 actual %b", cur_test,
				$sampled({data_v_o, am_v_o, aligned_o, wb_ack_o}));
		end
	a_mark: assert property (@(posedge clk) disable iff (reset_i)
		data_v_o |-> (mark_mask == '0 || mark_mask == '1))
		else begin
			err_cnt++;
			$display("mismatch %s marker mask expected all equal actual %b", cur_test,
				$sampled(mark_mask));
		end
	a_idx: assert property (@(posedge clk) disable iff (reset_i)
		(data_v_o && mark_mask == '0) |-> idx_ok)
		else begin
			err_cnt++;
			$display("mismatch %s block index expected %0h actual %0h", cur_test,
				$sampled(out_blk[0].pl.raw[63:8]), $sampled(bad_idx));
		end
	a_amv: assert property (@(posedge clk) disable iff (reset_i)
		am_v_o == (data_v_o && mark_mask == '1))
		else begin
			err_cnt++;
			$display("mismatch %s am_v_o expected %b actual %b", cur_test,
				$sampled(data_v_o && mark_mask == '1), $sampled(am_v_o));
		end
	a_ack_len: assert property (@(posedge clk) disable iff (reset_i) wb_ack_o |=> !wb_ack_o)
		else begin
			err_cnt++;
			$display("wishbone ack held longer than one cycle in test %s", cur_test);
		end
	a_ack_stb: assert property (@(posedge clk) disable iff (reset_i)
		wb_ack_o |-> (wb_cyc_i && wb_stb_i))
		else begin
			err_cnt++;
			$display("wishbone ack without a strobe in test %s", cur_test);
		end
	a_unaligned: assert property (@(posedge clk) disable iff (reset_i)
		hold_unaligned |-> !aligned_o)
		else begin
			err_cnt++;
			$display("mismatch %s aligned_o expected 0 actual 1", cur_test);
		end

	// one classic cycle, stb held across the edge where ack falls
	task automatic wb_access(input logic we, input logic [WB_AW-1:0] adr,
		input logic [WB_DW-1:0] wdat, output logic [WB_DW-1:0] rdat);
		int t;
		logic got;
		@(negedge clk);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = adr;
		wb_dat_i = wdat;
		access_cnt++;
		got = 1'b0;
		t = 0;
		rdat = '0;
		while (!got && t < WB_TIMEOUT) begin
			@(negedge clk);
			t++;
			if (wb_ack_o) begin
				got = 1'b1;
				rdat = wb_dat_o;
			end
		end
		if (got) begin
			@(negedge clk);
		end
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		assert (got) else begin
			err_cnt++;
			$display("no wishbone ack within %0d cycles in test %s", WB_TIMEOUT, cur_test);
		end
	endtask

	task automatic wait_aligned(input logic level, input int limit);
		int t;
		t = 0;
		while (aligned_o !== level && t < limit) begin
			@(negedge clk);
			t++;
		end
		assert (aligned_o === level) else begin
			err_cnt++;
			$display("aligned_o did not go %0d within %0d cycles in test %s", level, limit,
				cur_test);
		end
	endtask

	// slowest lane reads zero, the others their lead over it
	task automatic check_skew_reg();
		logic [WB_DW-1:0] rd;
		logic [WB_DW-1:0] exp_v;
		int mx;
		mx = 0;
		exp_v = '0;
		for (int l = 0; l < LANE_N; l++) begin
			if (skew[l] > mx) mx = skew[l];
		end
		for (int l = 0; l < LANE_N; l++) begin
			exp_v[l*8 +: 8] = 8'(mx - skew[l]);
		end
		wb_access(1'b0, REG_SKEW, '0, rd);
		assert (rd == exp_v) else begin
			err_cnt++;
			$display("mismatch %s skew expected %h actual %h", cur_test, exp_v, rd);
		end
	endtask

	task automatic check_status(input logic [WB_DW-1:0] exp_v);
		logic [WB_DW-1:0] rd;
		wb_access(1'b0, REG_STATUS, '0, rd);
		assert (rd == exp_v) else begin
			err_cnt++;
			$display("mismatch %s status expected %h actual %h", cur_test, exp_v, rd);
		end
	endtask

	// read REG_OVF until it passes a given value
	task automatic poll_ovf(input logic [WB_DW-1:0] above, output logic [WB_DW-1:0] val);
		int t;
		val = '0;
		t = 0;
		while (val <= above && t < 40) begin
			wb_access(1'b0, REG_OVF, '0, val);
			t++;
		end
		assert (val > above) else begin
			err_cnt++;
			$display("overflow count stayed at %0d in test %s", val, cur_test);
		end
	endtask

	// lane controls change after a rising edge, the next falling edge applies them
	task automatic set_lane_lock(input logic [LANE_N-1:0] mask);
		@(posedge clk);
		lock_v = mask;
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_base = err_cnt;
	endtask

	task automatic finish_test();
		tests_run++;
		if (err_cnt == err_base) begin
			$display("test %s ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", cur_test, err_cnt - err_base);
		end
	endtask

	initial begin : main
		logic [WB_DW-1:0] rd;
		logic [WB_DW-1:0] ovf_a;
		logic [WB_DW-1:0] ovf_b;
		int base;
		int t;
		reset_i = 1'b1;
		lock_i = '0;
		valid_i = '0;
		data_i = '0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		repeat (5) @(negedge clk);
		reset_i = 1'b0;

		start_test("reset_align");
		assert (!aligned_o && !data_v_o && !am_v_o && !wb_ack_o) else begin
			err_cnt++;
			$display("mismatch %s reset outputs expected 0000 actual %b", cur_test,
				{data_v_o, am_v_o, aligned_o, wb_ack_o});
		end
		wait_aligned(1'b1, ALIGN_TIMEOUT);
		finish_test();

		// index and marker checks run in the assertions above
		start_test("lane_match");
		base = am_v_cnt;
		t = 0;
		while (am_v_cnt < base + 3 && t < ALIGN_TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		assert (am_v_cnt >= base + 3) else begin
			err_cnt++;
			$display("aligned markers did not come out in test %s", cur_test);
		end
		finish_test();

		start_test("skew_reg");
		check_skew_reg();
		finish_test();

		start_test("relock");
		set_lane_lock(4'b1101);
		wait_aligned(1'b0, 10);
		check_status(32'h0000_000D);
		set_lane_lock(4'b1111);
		wait_aligned(1'b1, ALIGN_TIMEOUT);
		check_status(32'h0000_010F);
		wb_access(1'b1, REG_CTRL, 32'h1, rd);
		wait_aligned(1'b0, 10);
		wait_aligned(1'b1, ALIGN_TIMEOUT);
		check_skew_reg();
		finish_test();

		// lane 2 drops lock while its delay grows past the buffer depth
		start_test("overflow");
		set_lane_lock(4'b1011);
		wait_aligned(1'b0, 10);
		hold_unaligned = 1'b1;
		@(posedge clk);
		skew[2] = MAX_SKEW_BLOCK_N + 2;
		set_lane_lock(4'b1111);
		wb_access(1'b0, REG_OVF, '0, rd);
		poll_ovf(rd, ovf_a);
		poll_ovf(ovf_a, ovf_b);
		finish_test();

		start_test("wb_ack");
		assert (ack_cnt == access_cnt) else begin
			err_cnt++;
			$display("mismatch %s ack count expected %0d actual %0d", cur_test, access_cnt,
				ack_cnt);
		end
		finish_test();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
source/pcs_pkg.sv
source/lane_if.sv
source/am_detect.sv
source/deskew_lane.sv
source/deskew_ctrl.sv
source/deskew_csr.sv
source/pcs_rx_deskew_top.sv
tb/tb_pcs_rx_deskew.sv
